// File: src/fixed_point_pkg.sv
`default_nettype none

package fixed_point_pkg;

  // Data and grid share one Q format
  localparam int SAMPLE_W    = 16;
  localparam int SAMPLE_FRAC = 12;

  // Scale factor format
  localparam int SCALE_W    = 16;
  localparam int SCALE_FRAC = 12;

  // Result word width
  localparam int RESULT_W = 16;

  // Full precision of difference times scale
  localparam int PRODUCT_W = SAMPLE_W + SCALE_W;

  typedef logic signed [SAMPLE_W-1:0]  sample_t;
  typedef logic signed [SCALE_W-1:0]   scale_t;
  typedef logic signed [PRODUCT_W-1:0] product_t;
  typedef logic signed [RESULT_W-1:0]  result_t;

endpackage

`default_nettype wire

// File: src/frame_pkg.sv
`default_nettype none

package frame_pkg;

  localparam int NUM_SRC = 3;

  // Bit position of each operand stream in the per-stream control vectors
  typedef enum logic [1:0] {
    SRC_DATA  = 2'd0,
    SRC_GRID  = 2'd1,
    SRC_SCALE = 2'd2
  } src_e;

endpackage

`default_nettype wire

// File: src/stream_skid.sv
`timescale 1ns/1ps
`default_nettype none

module stream_skid #(
  parameter int WIDTH = 17
) (
  input  logic             clk,
  input  logic             rst,

  input  logic [WIDTH-1:0] in_data,
  input  logic             in_valid,
  output logic             in_ready,

  output logic [WIDTH-1:0] out_data,
  output logic             out_valid,
  input  logic             out_ready
);

  // Overflow entry filled when the output register is stalled
  logic [WIDTH-1:0] skid_data;
  logic             skid_valid;

  logic in_fire;
  logic out_load;

  // Ready comes from a register only, so the ready path is cut here
  assign in_ready = ~skid_valid;

  assign in_fire  = in_valid & in_ready;

  // Output register may take a new beat when empty or being drained
  assign out_load = out_ready | ~out_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else begin
      if (out_load) begin
        // Skid entry drains first; input is blocked while it is full
        out_valid  <= skid_valid | in_valid;
        skid_valid <= 1'b0;
      end else if (in_fire) begin
        skid_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (out_load) begin
      out_data <= skid_valid ? skid_data : in_data;
    end
    if (~out_load && in_fire) begin
      skid_data <= in_data;
    end
  end

endmodule

`default_nettype wire

// File: src/operand_align.sv
`timescale 1ns/1ps
`default_nettype none

module operand_align (
  input  logic                      clk,
  input  logic                      rst,

  input  fixed_point_pkg::sample_t  data,
  input  logic                      data_valid,
  output logic                      data_ready,
  input  logic                      data_last,

  input  fixed_point_pkg::sample_t  grid,
  input  logic                      grid_valid,
  output logic                      grid_ready,
  input  logic                      grid_last,

  input  fixed_point_pkg::scale_t   scale,
  input  logic                      scale_valid,
  output logic                      scale_ready,
  input  logic                      scale_last,

  output fixed_point_pkg::sample_t  op_sample,
  output fixed_point_pkg::sample_t  op_grid,
  output fixed_point_pkg::scale_t   op_scale,
  output logic                      op_valid,
  output logic                      op_last,
  input  logic                      op_ready
);

  localparam int SAMPLE_WORD_W = fixed_point_pkg::SAMPLE_W + 1;
  localparam int SCALE_WORD_W  = fixed_point_pkg::SCALE_W + 1;

  // Buffered stream words with last above the value
  logic [SAMPLE_WORD_W-1:0] data_word;
  logic [SAMPLE_WORD_W-1:0] grid_word;
  logic [SCALE_WORD_W-1:0]  scale_word;

  // Per-stream control indexed by frame_pkg::src_e
  logic [frame_pkg::NUM_SRC-1:0] buf_valid;
  logic [frame_pkg::NUM_SRC-1:0] buf_last;
  logic [frame_pkg::NUM_SRC-1:0] buf_ready;
  logic [frame_pkg::NUM_SRC-1:0] hold;

  logic join_fire;

  stream_skid #(
    .WIDTH (SAMPLE_WORD_W)
  ) u_data_skid (
    .clk       (clk),
    .rst       (rst),
    .in_data   ({data_last, data}),
    .in_valid  (data_valid),
    .in_ready  (data_ready),
    .out_data  (data_word),
    .out_valid (buf_valid[frame_pkg::SRC_DATA]),
    .out_ready (buf_ready[frame_pkg::SRC_DATA])
  );

  stream_skid #(
    .WIDTH (SAMPLE_WORD_W)
  ) u_grid_skid (
    .clk       (clk),
    .rst       (rst),
    .in_data   ({grid_last, grid}),
    .in_valid  (grid_valid),
    .in_ready  (grid_ready),
    .out_data  (grid_word),
    .out_valid (buf_valid[frame_pkg::SRC_GRID]),
    .out_ready (buf_ready[frame_pkg::SRC_GRID])
  );

  stream_skid #(
    .WIDTH (SCALE_WORD_W)
  ) u_scale_skid (
    .clk       (clk),
    .rst       (rst),
    .in_data   ({scale_last, scale}),
    .in_valid  (scale_valid),
    .in_ready  (scale_ready),
    .out_data  (scale_word),
    .out_valid (buf_valid[frame_pkg::SRC_SCALE]),
    .out_ready (buf_ready[frame_pkg::SRC_SCALE])
  );

  // Unpack the buffered words
  assign op_sample = data_word[fixed_point_pkg::SAMPLE_W-1:0];
  assign op_grid   = grid_word[fixed_point_pkg::SAMPLE_W-1:0];
  assign op_scale  = scale_word[fixed_point_pkg::SCALE_W-1:0];

  assign buf_last[frame_pkg::SRC_DATA]  = data_word[fixed_point_pkg::SAMPLE_W];
  assign buf_last[frame_pkg::SRC_GRID]  = grid_word[fixed_point_pkg::SAMPLE_W];
  assign buf_last[frame_pkg::SRC_SCALE] = scale_word[fixed_point_pkg::SCALE_W];

  // An operand set exists only when every stream has a beat
  assign op_valid  = &buf_valid;
  assign op_last   = &buf_last;
  assign join_fire = op_valid & op_ready;

  // A finished shorter frame keeps presenting its final beat
  // until the longest frame reaches its own last
  assign hold = buf_last & {frame_pkg::NUM_SRC{~op_last}};

  assign buf_ready = {frame_pkg::NUM_SRC{join_fire}} & ~hold;

endmodule

`default_nettype wire

// File: src/sub_mult_execute.sv
`timescale 1ns/1ps
`default_nettype none

module sub_mult_execute #(
  parameter int RESULT_FRAC = 12
) (
  input  logic                      clk,
  input  logic                      rst,

  input  fixed_point_pkg::sample_t  op_sample,
  input  fixed_point_pkg::sample_t  op_grid,
  input  fixed_point_pkg::scale_t   op_scale,
  input  logic                      op_valid,
  input  logic                      op_last,
  output logic                      op_ready,

  output fixed_point_pkg::result_t  ex_result,
  output logic                      ex_valid,
  output logic                      ex_last,
  input  logic                      ex_ready
);

  localparam int PRODUCT_FRAC = fixed_point_pkg::SAMPLE_FRAC + fixed_point_pkg::SCALE_FRAC;

  // First product bit of the result
  localparam int RESULT_LSB = PRODUCT_FRAC - RESULT_FRAC;

  // Product sign-extended so a small RESULT_FRAC still selects in range
  localparam int EXT_W = fixed_point_pkg::PRODUCT_W + fixed_point_pkg::RESULT_W;

  if (RESULT_FRAC < 0 || RESULT_FRAC > PRODUCT_FRAC) begin : g_bad_frac
    $error("RESULT_FRAC out of range 0 to %0d", PRODUCT_FRAC);
  end

  fixed_point_pkg::sample_t  diff;
  fixed_point_pkg::product_t product;
  logic signed [EXT_W-1:0]   product_ext;
  fixed_point_pkg::result_t  result_next;

  // Difference wraps to the sample width
  assign diff = op_sample - op_grid;

  assign product     = fixed_point_pkg::product_t'(diff)
                     * fixed_point_pkg::product_t'(op_scale);
  assign product_ext = EXT_W'(product);

  // Truncating re-alignment to the result format
  assign result_next = product_ext[RESULT_LSB +: fixed_point_pkg::RESULT_W];

  // Stage moves when empty or when the next stage takes its beat
  assign op_ready = ~ex_valid | ex_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid <= 1'b0;
    end else if (op_ready) begin
      ex_valid <= op_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (op_ready) begin
      ex_result <= result_next;
      ex_last   <= op_last;
    end
  end

endmodule

`default_nettype wire

// File: src/sub_mult.sv
`timescale 1ns/1ps
`default_nettype none

module sub_mult #(
  parameter int RESULT_FRAC = 12
) (
  input  logic                      clk,
  input  logic                      rst,

  input  fixed_point_pkg::sample_t  data,
  input  logic                      data_valid,
  output logic                      data_ready,
  input  logic                      data_last,

  input  fixed_point_pkg::sample_t  grid,
  input  logic                      grid_valid,
  output logic                      grid_ready,
  input  logic                      grid_last,

  input  fixed_point_pkg::scale_t   scale,
  input  logic                      scale_valid,
  output logic                      scale_ready,
  input  logic                      scale_last,

  output fixed_point_pkg::result_t  result,
  output logic                      result_valid,
  input  logic                      result_ready,
  output logic                      result_last
);

  localparam int RESULT_WORD_W = fixed_point_pkg::RESULT_W + 1;

  fixed_point_pkg::sample_t op_sample;
  fixed_point_pkg::sample_t op_grid;
  fixed_point_pkg::scale_t  op_scale;
  logic                     op_valid;
  logic                     op_last;
  logic                     op_ready;

  fixed_point_pkg::result_t ex_result;
  logic                     ex_valid;
  logic                     ex_last;
  logic                     ex_ready;

  logic [RESULT_WORD_W-1:0] result_word;

  // Decode stage with input buffering and frame join
  operand_align u_align (
    .clk         (clk),
    .rst         (rst),
    .data        (data),
    .data_valid  (data_valid),
    .data_ready  (data_ready),
    .data_last   (data_last),
    .grid        (grid),
    .grid_valid  (grid_valid),
    .grid_ready  (grid_ready),
    .grid_last   (grid_last),
    .scale       (scale),
    .scale_valid (scale_valid),
    .scale_ready (scale_ready),
    .scale_last  (scale_last),
    .op_sample   (op_sample),
    .op_grid     (op_grid),
    .op_scale    (op_scale),
    .op_valid    (op_valid),
    .op_last     (op_last),
    .op_ready    (op_ready)
  );

  // Execute stage to subtract, multiply and re-align
  sub_mult_execute #(
    .RESULT_FRAC (RESULT_FRAC)
  ) u_execute (
    .clk       (clk),
    .rst       (rst),
    .op_sample (op_sample),
    .op_grid   (op_grid),
    .op_scale  (op_scale),
    .op_valid  (op_valid),
    .op_last   (op_last),
    .op_ready  (op_ready),
    .ex_result (ex_result),
    .ex_valid  (ex_valid),
    .ex_last   (ex_last),
    .ex_ready  (ex_ready)
  );

  // Result buffering toward the consumer
  stream_skid #(
    .WIDTH (RESULT_WORD_W)
  ) u_result_skid (
    .clk       (clk),
    .rst       (rst),
    .in_data   ({ex_last, ex_result}),
    .in_valid  (ex_valid),
    .in_ready  (ex_ready),
    .out_data  (result_word),
    .out_valid (result_valid),
    .out_ready (result_ready)
  );

  assign result      = result_word[fixed_point_pkg::RESULT_W-1:0];
  assign result_last = result_word[fixed_point_pkg::RESULT_W];

endmodule

`default_nettype wire

// File: dv/sub_mult_sva.sv
`timescale 1ns/1ps
`default_nettype none

module sub_mult_sva (
  input  logic                          clk,
  input  logic                          rst,
  input  fixed_point_pkg::sample_t      data,
  input  logic                          data_valid,
  input  logic                          data_ready,
  input  fixed_point_pkg::sample_t      op_sample,
  input  fixed_point_pkg::sample_t      op_grid,
  input  fixed_point_pkg::scale_t       op_scale,
  input  logic                          op_valid,
  input  logic                          op_last,
  input  logic                          op_ready,
  input  logic [frame_pkg::NUM_SRC-1:0] buf_valid,
  input  logic [frame_pkg::NUM_SRC-1:0] hold
);

  // Input stream keeps its beat until it transfers
  assert property (@(posedge clk) disable iff (rst)
    data_valid && !data_ready |=> data_valid && $stable(data))
    else $error("data stream dropped or changed a pending beat");

  // Joined operand set stays put while stalled
  assert property (@(posedge clk) disable iff (rst)
    op_valid && !op_ready |=> op_valid && $stable({op_sample, op_grid, op_scale, op_last}))
    else $error("operand set changed while stalled");

  // Held final beats survive a joined transfer
  assert property (@(posedge clk) disable iff (rst)
    op_valid && op_ready && hold[frame_pkg::SRC_DATA]
      |=> buf_valid[frame_pkg::SRC_DATA] && $stable(op_sample))
    else $error("held data beat was not kept");

  assert property (@(posedge clk) disable iff (rst)
    op_valid && op_ready && hold[frame_pkg::SRC_GRID]
      |=> buf_valid[frame_pkg::SRC_GRID] && $stable(op_grid))
    else $error("held grid beat was not kept");

  assert property (@(posedge clk) disable iff (rst)
    op_valid && op_ready && hold[frame_pkg::SRC_SCALE]
      |=> buf_valid[frame_pkg::SRC_SCALE] && $stable(op_scale))
    else $error("held scale beat was not kept");

endmodule

`default_nettype wire

// File: dv/tb_sub_mult.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sub_mult;

  localparam int RESULT_FRAC = 12;
  localparam int SHIFT = fixed_point_pkg::SAMPLE_FRAC + fixed_point_pkg::SCALE_FRAC - RESULT_FRAC;

  logic clk;
  logic rst;

  fixed_point_pkg::sample_t data;
  fixed_point_pkg::sample_t grid;
  fixed_point_pkg::scale_t  scale;
  logic data_valid;
  logic data_ready;
  logic data_last;
  logic grid_valid;
  logic grid_ready;
  logic grid_last;
  logic scale_valid;
  logic scale_ready;
  logic scale_last;
  fixed_point_pkg::result_t result;
  logic result_valid;
  logic result_ready;
  logic result_last;

  // Stream index follows frame_pkg::src_e
  // Each word holds {last, value}
  logic [2:0]  in_valid;
  logic [2:0]  in_ready;
  logic [16:0] in_word [3];

  logic [16:0] data_q[$];
  logic [16:0] grid_q[$];
  logic [16:0] scale_q[$];
  logic [16:0] exp_q[$];

  logic [31:0] rng_state;
  int errors;
  int passes;

  assign data        = in_word[frame_pkg::SRC_DATA][15:0];
  assign data_last   = in_word[frame_pkg::SRC_DATA][16];
  assign data_valid  = in_valid[frame_pkg::SRC_DATA];
  assign grid        = in_word[frame_pkg::SRC_GRID][15:0];
  assign grid_last   = in_word[frame_pkg::SRC_GRID][16];
  assign grid_valid  = in_valid[frame_pkg::SRC_GRID];
  assign scale       = in_word[frame_pkg::SRC_SCALE][15:0];
  assign scale_last  = in_word[frame_pkg::SRC_SCALE][16];
  assign scale_valid = in_valid[frame_pkg::SRC_SCALE];
  assign in_ready    = {scale_ready, grid_ready, data_ready};

  sub_mult #(
    .RESULT_FRAC (RESULT_FRAC)
  ) DUT (
    .clk (clk), .rst (rst),
    .data (data), .data_valid (data_valid), .data_ready (data_ready), .data_last (data_last),
    .grid (grid), .grid_valid (grid_valid), .grid_ready (grid_ready), .grid_last (grid_last),
    .scale (scale), .scale_valid (scale_valid), .scale_ready (scale_ready),
    .scale_last (scale_last),
    .result (result), .result_valid (result_valid), .result_ready (result_ready),
    .result_last (result_last)
  );

  bind operand_align sub_mult_sva u_sva (
    .clk (clk), .rst (rst), .data (data), .data_valid (data_valid), .data_ready (data_ready),
    .op_sample (op_sample), .op_grid (op_grid), .op_scale (op_scale), .op_valid (op_valid),
    .op_last (op_last), .op_ready (op_ready), .buf_valid (buf_valid), .hold (hold)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Reference model of the wrapped difference times scale with truncation
  function automatic fixed_point_pkg::result_t model_result(input logic [15:0] d,
      input logic [15:0] g, input logic [15:0] s);
    logic signed [15:0] diff;
    logic signed [31:0] prod;
    logic signed [31:0] shifted;
    diff = d - g;
    prod = 32'(diff) * 32'($signed(s));
    shifted = prod >>> SHIFT;
    return shifted[15:0];
  endfunction

  function automatic int pending(input int id);
    case (id)
      0: return data_q.size();
      1: return grid_q.size();
      default: return scale_q.size();
    endcase
  endfunction

  function automatic logic [16:0] front_word(input int id);
    case (id)
      0: return data_q[0];
      1: return grid_q[0];
      default: return scale_q[0];
    endcase
  endfunction

  function automatic void pop_word(input int id);
    case (id)
      0: void'(data_q.pop_front());
      1: void'(grid_q.pop_front());
      default: void'(scale_q.pop_front());
    endcase
  endfunction

  task automatic check_result(input string name, input fixed_point_pkg::result_t exp,
      input fixed_point_pkg::result_t act);
    if (exp !== act) begin
      $display("Fail %s result expected %0d actual %0d", name, exp, act);
      errors++;
    end else begin
      passes++;
    end
  endtask

  task automatic check_last(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("Fail %s last expected %0b actual %0b", name, exp, act);
      errors++;
    end else begin
      passes++;
    end
  endtask

  // Frame length mode 0 equal, 1 unequal, 2 single or long, 3 random
  task automatic make_frame(input int mode);
    int len [3];
    logic [15:0] vals [3][8];
    logic [31:0] r;
    int common;
    int n;
    r = next_rand();
    common = int'(r % 8) + 1;
    n = 0;
    for (int k = 0; k < 3; k++) begin
      r = next_rand();
      case (mode)
        0: len[k] = common;
        2: len[k] = r[4] ? 1 : 8;
        default: len[k] = int'(r % 8) + 1;
      endcase
      if (len[k] > n) n = len[k];
      for (int j = 0; j < len[k]; j++) begin
        r = next_rand();
        vals[k][j] = r[23:8];
        case (k)
          0: data_q.push_back({j == len[k] - 1, vals[k][j]});
          1: grid_q.push_back({j == len[k] - 1, vals[k][j]});
          default: scale_q.push_back({j == len[k] - 1, vals[k][j]});
        endcase
      end
    end
    for (int i = 0; i < n; i++) begin
      exp_q.push_back({i == n - 1,
        model_result(vals[0][(i < len[0]) ? i : len[0] - 1],
                     vals[1][(i < len[1]) ? i : len[1] - 1],
                     vals[2][(i < len[2]) ? i : len[2] - 1])});
    end
  endtask

  task automatic check_reset();
    int cycles;
    int err_start;
    err_start = errors;
    cycles = 0;
    while (in_ready !== 3'b111) begin
      if (cycles == 10) begin
        $display("Input readies did not rise after reset");
        errors++;
        break;
      end
      @(negedge clk);
      cycles++;
    end
    repeat (8) begin
      @(negedge clk);
      if (result_valid !== 1'b0) begin
        $display("Result valid went high with no input");
        errors++;
      end
    end
    $display("Test reset finished, %0d errors", errors - err_start);
  endtask

  task automatic run_test(input string name, input int frames, input int mode, input bit gaps);
    int err_start;
    int cycles;
    int limit;
    logic [2:0] fired;
    logic [16:0] exp_word;
    logic [31:0] r;
    err_start = errors;
    for (int f = 0; f < frames; f++) make_frame(mode);
    limit = frames * 8 * (gaps ? 8 : 3) + 100;
    fired = 3'b000;
    cycles = 0;
    while (exp_q.size() != 0) begin
      if (cycles == limit) begin
        $display("Timeout in %s waiting for %0d more results", name, exp_q.size());
        errors++;
        break;
      end
      @(posedge clk);
      #1;
      for (int k = 0; k < 3; k++) begin
        if (fired[k]) begin
          pop_word(k);
          in_valid[k] = 1'b0;
        end
        if (!in_valid[k] && pending(k) != 0) begin
          r = next_rand();
          if (!gaps || r[1:0] != 2'b00) begin
            in_valid[k] = 1'b1;
            in_word[k]  = front_word(k);
          end
        end
      end
      r = next_rand();
      result_ready = !gaps || r[2:0] != 3'b000;
      @(negedge clk);
      fired = in_valid & in_ready;
      if (result_valid && result_ready) begin
        exp_word = exp_q.pop_front();
        check_result(name, exp_word[15:0], result);
        check_last(name, exp_word[16], result_last);
      end
      cycles++;
    end
    @(posedge clk);
    #1;
    in_valid = 3'b000;
    result_ready = 1'b1;
    data_q.delete();
    grid_q.delete();
    scale_q.delete();
    exp_q.delete();
    // Nothing may follow the final frame
    repeat (10) begin
      @(negedge clk);
      if (result_valid) begin
        $display("Extra result beat appeared after %s", name);
        errors++;
      end
    end
    $display("Test %s finished, %0d errors", name, errors - err_start);
  endtask

  initial begin
    rst = 1'b1;
    in_valid = 3'b000;
    for (int k = 0; k < 3; k++) in_word[k] = '0;
    result_ready = 1'b0;
    rng_state = 32'h28d;
    errors = 0;
    passes = 0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    check_reset();
    run_test("equal_frames", 20, 0, 1'b0);
    run_test("unequal_frames", 20, 1, 1'b0);
    run_test("single_beat_mix", 30, 2, 1'b0);
    run_test("random_backpressure", 200, 3, 1'b1);
    $display("Checks passed %0d, errors %0d", passes, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
src/fixed_point_pkg.sv
src/frame_pkg.sv
src/stream_skid.sv
src/operand_align.sv
src/sub_mult_execute.sv
src/sub_mult.sv
dv/sub_mult_sva.sv
dv/tb_sub_mult.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  --top-module tb_sub_mult \
  -Mdir obj_dir \
  -f build.f

./obj_dir/Vtb_sub_mult > sim.log 2>&1 || true
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
  exit 1
fi

if ! grep -q "=== PASS ===" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi

exit 0
